/* blur_kernel.sv */
`timescale 1ns/1ps

module blur_kernel (
    input  face_blur_pkg::window_t window,
    output face_blur_pkg::pixel_t  blurred
);

    logic [face_blur_pkg::SUM_WIDTH-1:0] sum_red;
    logic [face_blur_pkg::SUM_WIDTH-1:0] sum_green;
    logic [face_blur_pkg::SUM_WIDTH-1:0] sum_blue;

    // One channel value scaled by its tap weight
    function automatic logic [face_blur_pkg::SUM_WIDTH-1:0] weigh(
        input logic [face_blur_pkg::CHANNEL_WIDTH-1:0] value,
        input int                                      r,
        input int                                      c
    );
        logic [face_blur_pkg::SUM_WIDTH-1:0] wide;
        wide = face_blur_pkg::SUM_WIDTH'(value);
        if (face_blur_pkg::BLUR_ZERO[r][c]) begin
            return '0;
        end
        return wide << face_blur_pkg::BLUR_SHIFT[r][c];
    endfunction

    // Largest sum is 15 * 64 so the sum width never overflows
    always_comb begin
        sum_red   = '0;
        sum_green = '0;
        sum_blue  = '0;
        for (int r = 0; r < face_blur_pkg::KERNEL_ROWS; r++) begin
            for (int c = 0; c < face_blur_pkg::KERNEL_COLS; c++) begin
                sum_red   = sum_red   + weigh(window[r][c].red,   r, c);
                sum_green = sum_green + weigh(window[r][c].green, r, c);
                sum_blue  = sum_blue  + weigh(window[r][c].blue,  r, c);
            end
        end
    end

    // Divide by the kernel sum of 64
    assign blurred.red   = face_blur_pkg::CHANNEL_WIDTH'(sum_red   >> face_blur_pkg::NORM_SHIFT);
    assign blurred.green = face_blur_pkg::CHANNEL_WIDTH'(sum_green >> face_blur_pkg::NORM_SHIFT);
    assign blurred.blue  = face_blur_pkg::CHANNEL_WIDTH'(sum_blue  >> face_blur_pkg::NORM_SHIFT);

endmodule

/* face_blur_pkg.sv */
package face_blur_pkg;

    // Frame geometry
    localparam int IMAGE_WIDTH   = 8;
    localparam int IMAGE_HEIGHT  = 6;
    localparam int COL_CNT_WIDTH = $clog2(IMAGE_WIDTH);
    localparam int ROW_CNT_WIDTH = $clog2(IMAGE_HEIGHT);
    localparam int COORD_WIDTH   = 8;

    // History covers four full rows plus the partial row of the newest taps
    localparam int KERNEL_ROWS   = 5;
    localparam int KERNEL_COLS   = 7;
    localparam int HISTORY_DEPTH = 4 * IMAGE_WIDTH + KERNEL_COLS;

    // Weight of a tap is 1 << shift; weights add up to 64
    localparam int BLUR_SHIFT [KERNEL_ROWS][KERNEL_COLS] = '{
        '{0, 0, 0, 0, 0, 1, 1},
        '{0, 0, 0, 0, 1, 1, 1},
        '{0, 0, 0, 1, 1, 1, 2},
        '{0, 0, 1, 1, 1, 2, 2},
        '{0, 1, 1, 1, 2, 2, 2}
    };
    localparam bit BLUR_ZERO [KERNEL_ROWS][KERNEL_COLS] = '{
        '{1, 1, 0, 0, 0, 0, 0},
        '{1, 0, 0, 0, 0, 0, 0},
        '{0, 0, 0, 0, 0, 0, 0},
        '{0, 0, 0, 0, 0, 0, 0},
        '{0, 0, 0, 0, 0, 0, 0}
    };
    localparam int CHANNEL_WIDTH = 4;
    localparam int NORM_SHIFT    = 6;
    localparam int SUM_WIDTH     = CHANNEL_WIDTH + NORM_SHIFT;

    // Wishbone register map in word addresses
    localparam int WB_ADR_WIDTH  = 3;
    localparam int WB_DATA_WIDTH = 32;
    localparam logic [WB_ADR_WIDTH-1:0] REG_CTRL      = 3'd0;
    localparam logic [WB_ADR_WIDTH-1:0] REG_COL_START = 3'd1;
    localparam logic [WB_ADR_WIDTH-1:0] REG_COL_END   = 3'd2;
    localparam logic [WB_ADR_WIDTH-1:0] REG_ROW_START = 3'd3;
    localparam logic [WB_ADR_WIDTH-1:0] REG_ROW_END   = 3'd4;

    typedef struct packed {
        logic [CHANNEL_WIDTH-1:0] red;
        logic [CHANNEL_WIDTH-1:0] green;
        logic [CHANNEL_WIDTH-1:0] blue;
    } pixel_t;

    typedef struct packed {
        pixel_t pixel;
        logic   sop;
        logic   eop;
    } stream_beat_t;

    typedef struct packed {
        logic [COORD_WIDTH-1:0] row;
        logic [COORD_WIDTH-1:0] col;
    } pixel_pos_t;

    typedef struct packed {
        logic                   enable;
        logic [COORD_WIDTH-1:0] col_start;
        logic [COORD_WIDTH-1:0] col_end;
        logic [COORD_WIDTH-1:0] row_start;
        logic [COORD_WIDTH-1:0] row_end;
    } blur_region_t;

    typedef pixel_t [KERNEL_ROWS-1:0][KERNEL_COLS-1:0] window_t;

endpackage

/* face_blur_tb.sv */
`timescale 1ns/1ps

module face_blur_tb;

    localparam int WAIT_LIMIT = 400;

    logic                                    clk;
    logic                                    reset;
    logic                                    sink_valid;
    logic                                    sink_ready;
    face_blur_pkg::stream_beat_t             sink_beat;
    logic                                    source_valid;
    logic                                    source_ready;
    face_blur_pkg::stream_beat_t             source_beat;
    logic                                    wb_cyc;
    logic                                    wb_stb;
    logic                                    wb_we;
    logic [face_blur_pkg::WB_ADR_WIDTH-1:0]  wb_adr;
    logic [face_blur_pkg::WB_DATA_WIDTH-1:0] wb_dat_w;
    logic [face_blur_pkg::WB_DATA_WIDTH-1:0] wb_dat_r;
    logic                                    wb_ack;

    // Random source stalls and sink gaps while set
    logic                        stall_mode;
    int                          cycle_count;
    int                          latency;
    logic                        stalled;
    face_blur_pkg::stream_beat_t held_beat;

    face_blur_pkg::stream_beat_t expected_beats[$];
    int                          accept_cycles[$];
    logic                        timed_beats[$];

    face_blur_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .sink_valid   (sink_valid),
        .sink_ready   (sink_ready),
        .sink_beat    (sink_beat),
        .source_valid (source_valid),
        .source_ready (source_ready),
        .source_beat  (source_beat),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                                $time, name, actual, expected));
        end
    endtask

    // One classic cycle that starts and ends 1 ns after a rising edge
    task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] data);
        int waited;
        waited = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr[face_blur_pkg::WB_ADR_WIDTH-1:0];
        wb_dat_w = we ? data : '0;
        @(negedge clk);
        while (!wb_ack) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("Wishbone ack never arrived");
            end
            @(negedge clk);
        end
        // Ack comes one clock after the request
        check_value("wb_ack delay", waited, 1);
        if (!we) begin
            check_value("wb_dat_r", wb_dat_r, data);
        end
        @(posedge clk);
        #1;
        check_value("wb_ack", wb_ack, 0);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic send_beat(input face_blur_pkg::stream_beat_t beat_in,
                             input face_blur_pkg::stream_beat_t expected);
        int gap;
        int waited;
        gap = stall_mode ? int'($urandom % 3) : 0;
        waited = 0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        sink_valid = 1'b1;
        sink_beat = beat_in;
        @(negedge clk);
        while (!sink_ready) begin
            // A ready source empties the output register in this cycle
            if (source_ready) begin
                check_value("sink_ready while source_ready high", sink_ready, 1);
            end
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("sink_ready stayed low, input beat was never accepted");
            end
            @(negedge clk);
        end
        // Accepted on the coming edge
        expected_beats.push_back(expected);
        accept_cycles.push_back(cycle_count);
        timed_beats.push_back(!stall_mode);
        @(posedge clk);
        #1;
        sink_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (expected_beats.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("output stream stopped before all expected beats arrived");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        #1;
        if (stall_mode) begin
            source_ready = ($urandom % 3) != 0;
        end else begin
            source_ready = 1'b1;
        end
    end

    // Outputs are sampled at the falling edge when they are stable
    always @(negedge clk) begin
        if (!reset && stalled) begin
            check_value("source_valid under stall", source_valid, 1);
            check_value("source_beat under stall", source_beat, held_beat);
        end
        if (!reset && source_valid && source_ready) begin
            if (expected_beats.size() == 0) begin
                abort_run("source produced a beat that was never sent");
            end else begin
                check_value("source_beat", source_beat, expected_beats.pop_front());
                latency = cycle_count - accept_cycles.pop_front();
                if (timed_beats.pop_front()) begin
                    check_value("source latency", latency, 1);
                end
            end
        end
        stalled = !reset && source_valid && !source_ready;
        held_beat = source_beat;
    end

    initial begin
        int                          fd;
        int                          code;
        int unsigned                 seed;
        logic                        done;
        logic [7:0]                  kind;
        logic [8*128-1:0]            line_buf;
        logic [31:0]                 field_a;
        logic [31:0]                 field_b;
        logic [31:0]                 in_px;
        logic [31:0]                 exp_px;
        face_blur_pkg::stream_beat_t beat_in;
        face_blur_pkg::stream_beat_t beat_exp;

        clk = 1'b0;
        reset = 1'b1;
        sink_valid = 1'b0;
        sink_beat = '0;
        source_ready = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        stall_mode = 1'b0;
        cycle_count = 0;
        stalled = 1'b0;
        held_beat = '0;
        seed = $urandom(19);

        fd = $fopen("face_blur_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open face_blur_testdata.txt");
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                case (kind)
                    "#": code = $fgets(line_buf, fd);
                    "w", "r": begin
                        code = $fscanf(fd, "%h %h", field_a, field_b);
                        if (code != 2) begin
                            abort_run("register line in test data is incomplete");
                        end
                        wait_drained();
                        wb_access(kind == "w", field_a, field_b);
                    end
                    "s": begin
                        code = $fscanf(fd, "%h", field_a);
                        if (code != 1) begin
                            abort_run("mode line in test data is incomplete");
                        end
                        wait_drained();
                        stall_mode = field_a[0];
                        @(posedge clk);
                        #1;
                    end
                    "p": begin
                        code = $fscanf(fd, "%h %h", field_a, field_b);
                        if (code != 2) begin
                            abort_run("pixel line in test data has no flags");
                        end
                        for (int i = 0; i < face_blur_pkg::IMAGE_WIDTH; i++) begin
                            code = $fscanf(fd, "%h %h", in_px, exp_px);
                            if (code != 2) begin
                                abort_run("pixel line in test data is too short");
                            end
                            beat_in.pixel = in_px[11:0];
                            beat_in.sop = field_a[0] && (i == 0);
                            beat_in.eop = field_b[0] && (i == face_blur_pkg::IMAGE_WIDTH - 1);
                            beat_exp = beat_in;
                            beat_exp.pixel = exp_px[11:0];
                            send_beat(beat_in, beat_exp);
                        end
                    end
                    default: abort_run($sformatf("unknown command %c in test data", kind));
                endcase
            end
        end
        $fclose(fd);

        wait_drained();
        // Nothing may follow the last expected beat
        check_value("source_valid after drain", source_valid, 0);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* face_blur_testdata.txt */
# w adr data = register write, r adr data = register read with expected data
# s mode = 1 for random stalls and gaps, p sop eop = one row of 8 input/expected pixel pairs
w 1 02
w 2 05
w 3 01
w 4 04
r 1 02
r 2 05
r 3 01
r 4 04
r 0 00
w 7 ff
r 7 00
r 5 00
# Frame with blurring disabled passes through unchanged
s 1
p 1 0 1f0 1f0 1e1 1e1 1d2 1d2 1c3 1c3 1b4 1b4 1a5 1a5 196 196 187 187
p 0 0 2f0 2f0 2e1 2e1 2d2 2d2 2c3 2c3 2b4 2b4 2a5 2a5 296 296 287 287
p 0 0 3f0 3f0 3e1 3e1 3d2 3d2 3c3 3c3 3b4 3b4 3a5 3a5 396 396 387 387
p 0 0 4f0 4f0 4e1 4e1 4d2 4d2 4c3 4c3 4b4 4b4 4a5 4a5 496 496 487 487
p 0 0 5f0 5f0 5e1 5e1 5d2 5d2 5c3 5c3 5b4 5b4 5a5 5a5 596 596 587 587
p 0 1 6f0 6f0 6e1 6e1 6d2 6d2 6c3 6c3 6b4 6b4 6a5 6a5 696 696 687 687
w 0 1
r 0 01
# Rows 1 to 4, columns 2 to 5 blurred, source always ready
s 0
p 1 0 f89 f89 f09 f09 f89 f89 f09 f09 f89 f89 f09 f09 f89 f89 f09 f09
p 0 0 f89 f89 f09 f09 f89 613 f09 624 f89 714 f09 724 f89 f89 f09 f09
p 0 0 f89 f89 f09 f09 f89 925 f09 a36 f89 a26 f09 a36 f89 f89 f09 f09
p 0 0 f89 f89 f09 f09 f89 c27 f09 c47 f89 c27 f09 d47 f89 f89 f09 f09
p 0 0 f89 f89 f09 f09 f89 e38 f09 e48 f89 e38 f09 f49 f89 f89 f09 f09
p 0 1 f89 f89 f09 f09 f89 f89 f09 f09 f89 f89 f09 f09 f89 f89 f09 f09
# Same frame again under back-pressure
s 1
p 1 0 f89 f89 f09 f09 f89 f89 f09 f09 f89 f89 f09 f09 f89 f89 f09 f09
p 0 0 f89 f89 f09 f09 f89 613 f09 624 f89 714 f09 724 f89 f89 f09 f09
p 0 0 f89 f89 f09 f09 f89 925 f09 a36 f89 a26 f09 a36 f89 f89 f09 f09
p 0 0 f89 f89 f09 f09 f89 c27 f09 c47 f89 c27 f09 d47 f89 f89 f09 f09
p 0 0 f89 f89 f09 f09 f89 e38 f09 e48 f89 e38 f09 f49 f89 f89 f09 f09
p 0 1 f89 f89 f09 f09 f89 f89 f09 f09 f89 f89 f09 f09 f89 f89 f09 f09

/* face_blur_top.sv */
`timescale 1ns/1ps

module face_blur_top (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     sink_valid,
    output logic                                     sink_ready,
    input  face_blur_pkg::stream_beat_t              sink_beat,
    output logic                                     source_valid,
    input  logic                                     source_ready,
    output face_blur_pkg::stream_beat_t              source_beat,
    input  logic                                     wb_cyc,
    input  logic                                     wb_stb,
    input  logic                                     wb_we,
    input  logic [face_blur_pkg::WB_ADR_WIDTH-1:0]   wb_adr,
    input  logic [face_blur_pkg::WB_DATA_WIDTH-1:0]  wb_dat_w,
    output logic [face_blur_pkg::WB_DATA_WIDTH-1:0]  wb_dat_r,
    output logic                                     wb_ack
);

    logic                         accept;
    face_blur_pkg::window_t       window;
    face_blur_pkg::pixel_pos_t    pos;
    face_blur_pkg::pixel_t        blurred;
    face_blur_pkg::blur_region_t  region;

    pixel_window window0 (
        .clk    (clk),
        .reset  (reset),
        .accept (accept),
        .beat   (sink_beat),
        .window (window),
        .pos    (pos)
    );

    blur_kernel kernel0 (
        .window  (window),
        .blurred (blurred)
    );

    region_regs regs0 (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .region   (region)
    );

    stream_output output0 (
        .clk          (clk),
        .reset        (reset),
        .sink_valid   (sink_valid),
        .beat         (sink_beat),
        .pos          (pos),
        .blurred      (blurred),
        .region       (region),
        .source_ready (source_ready),
        .sink_ready   (sink_ready),
        .accept       (accept),
        .source_valid (source_valid),
        .source_beat  (source_beat)
    );

endmodule

/* pixel_window.sv */
`timescale 1ns/1ps

module pixel_window (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        accept,
    input  face_blur_pkg::stream_beat_t beat,
    output face_blur_pkg::window_t      window,
    output face_blur_pkg::pixel_pos_t   pos
);

    // Entry 0 is the oldest pixel, the top entry the newest
    face_blur_pkg::pixel_t [face_blur_pkg::HISTORY_DEPTH-1:0] history;

    // Counters hold the position the next beat will take
    logic [face_blur_pkg::COL_CNT_WIDTH-1:0] col_cnt;
    logic [face_blur_pkg::ROW_CNT_WIDTH-1:0] row_cnt;
    logic [face_blur_pkg::COL_CNT_WIDTH-1:0] cur_col;
    logic [face_blur_pkg::ROW_CNT_WIDTH-1:0] cur_row;

    // A sop beat always lands in the top left corner
    always_comb begin
        if (beat.sop) begin
            cur_col = '0;
            cur_row = '0;
        end else begin
            cur_col = col_cnt;
            cur_row = row_cnt;
        end
    end

    assign pos.row = face_blur_pkg::COORD_WIDTH'(cur_row);
    assign pos.col = face_blur_pkg::COORD_WIDTH'(cur_col);

    always_ff @(posedge clk) begin
        if (reset) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (accept) begin
            if (cur_col == face_blur_pkg::COL_CNT_WIDTH'(face_blur_pkg::IMAGE_WIDTH - 1)) begin
                col_cnt <= '0;
                if (cur_row == face_blur_pkg::ROW_CNT_WIDTH'(face_blur_pkg::IMAGE_HEIGHT - 1)) begin
                    row_cnt <= '0;
                end else begin
                    row_cnt <= cur_row + 1'b1;
                end
            end else begin
                col_cnt <= cur_col + 1'b1;
                row_cnt <= cur_row;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            history <= '0;
        end else if (accept) begin
            if (beat.sop) begin
                // New frame starts from a blank history
                history <= '0;
            end else begin
                history[face_blur_pkg::HISTORY_DEPTH-2:0] <=
                    history[face_blur_pkg::HISTORY_DEPTH-1:1];
            end
            history[face_blur_pkg::HISTORY_DEPTH-1] <= beat.pixel;
        end
    end

    // Taps are one row apart every IMAGE_WIDTH entries
    always_comb begin
        for (int r = 0; r < face_blur_pkg::KERNEL_ROWS; r++) begin
            for (int c = 0; c < face_blur_pkg::KERNEL_COLS; c++) begin
                if (beat.sop) begin
                    window[r][c] = '0;
                end else begin
                    window[r][c] = history[r * face_blur_pkg::IMAGE_WIDTH + c];
                end
            end
        end
    end

endmodule

/* project.f */
face_blur_pkg.sv
pixel_window.sv
blur_kernel.sv
region_regs.sv
stream_output.sv
face_blur_top.sv
face_blur_tb.sv

/* region_regs.sv */
`timescale 1ns/1ps

module region_regs (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     wb_cyc,
    input  logic                                     wb_stb,
    input  logic                                     wb_we,
    input  logic [face_blur_pkg::WB_ADR_WIDTH-1:0]   wb_adr,
    input  logic [face_blur_pkg::WB_DATA_WIDTH-1:0]  wb_dat_w,
    output logic [face_blur_pkg::WB_DATA_WIDTH-1:0]  wb_dat_r,
    output logic                                     wb_ack,
    output face_blur_pkg::blur_region_t              region
);

    logic                                    request;
    logic [face_blur_pkg::WB_DATA_WIDTH-1:0] read_data;

    // New request only while no ack is out, so each cycle gets one ack
    assign request = wb_cyc && wb_stb && !wb_ack;

    always_comb begin
        case (wb_adr)
            face_blur_pkg::REG_CTRL:
                read_data = face_blur_pkg::WB_DATA_WIDTH'(region.enable);
            face_blur_pkg::REG_COL_START:
                read_data = face_blur_pkg::WB_DATA_WIDTH'(region.col_start);
            face_blur_pkg::REG_COL_END:
                read_data = face_blur_pkg::WB_DATA_WIDTH'(region.col_end);
            face_blur_pkg::REG_ROW_START:
                read_data = face_blur_pkg::WB_DATA_WIDTH'(region.row_start);
            face_blur_pkg::REG_ROW_END:
                read_data = face_blur_pkg::WB_DATA_WIDTH'(region.row_end);
            default:
                read_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= request;
        end
    end

    // Readback is sampled with the request and held while ack is high
    always_ff @(posedge clk) begin
        if (request) begin
            wb_dat_r <= read_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            region <= '0;
        end else if (request && wb_we) begin
            case (wb_adr)
                face_blur_pkg::REG_CTRL:
                    region.enable <= wb_dat_w[0];
                face_blur_pkg::REG_COL_START:
                    region.col_start <= wb_dat_w[face_blur_pkg::COORD_WIDTH-1:0];
                face_blur_pkg::REG_COL_END:
                    region.col_end <= wb_dat_w[face_blur_pkg::COORD_WIDTH-1:0];
                face_blur_pkg::REG_ROW_START:
                    region.row_start <= wb_dat_w[face_blur_pkg::COORD_WIDTH-1:0];
                face_blur_pkg::REG_ROW_END:
                    region.row_end <= wb_dat_w[face_blur_pkg::COORD_WIDTH-1:0];
                default: ;
            endcase
        end
    end

endmodule

/* stream_output.sv */
`timescale 1ns/1ps

module stream_output (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         sink_valid,
    input  face_blur_pkg::stream_beat_t  beat,
    input  face_blur_pkg::pixel_pos_t    pos,
    input  face_blur_pkg::pixel_t        blurred,
    input  face_blur_pkg::blur_region_t  region,
    input  logic                         source_ready,
    output logic                         sink_ready,
    output logic                         accept,
    output logic                         source_valid,
    output face_blur_pkg::stream_beat_t  source_beat
);

    logic                  in_region;
    face_blur_pkg::pixel_t chosen;

    // Room when the register is empty or drains this cycle
    assign sink_ready = !source_valid || source_ready;
    assign accept     = sink_valid && sink_ready;

    // Bounds are inclusive on all four sides
    assign in_region = region.enable
                    && (pos.row >= region.row_start) && (pos.row <= region.row_end)
                    && (pos.col >= region.col_start) && (pos.col <= region.col_end);

    assign chosen = in_region ? blurred : beat.pixel;

    always_ff @(posedge clk) begin
        if (reset) begin
            source_valid <= 1'b0;
        end else if (accept) begin
            source_valid <= 1'b1;
        end else if (source_ready) begin
            source_valid <= 1'b0;
        end
    end

    // Flags ride along with the chosen pixel
    always_ff @(posedge clk) begin
        if (accept) begin
            source_beat.pixel <= chosen;
            source_beat.sop   <= beat.sop;
            source_beat.eop   <= beat.eop;
        end
    end

endmodule
